//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	localparam int WORD_BYTES = WORD_WIDTH / 8;
	localparam int BEATS_PER_LINE = 4;
	localparam int LINE_WIDTH = WORD_WIDTH * BEATS_PER_LINE;
	localparam int OFFSET_BITS = 4;
	localparam int PAGE_WIDTH = ADDR_WIDTH - OFFSET_BITS;
	localparam int WORD_SEL_WIDTH = 2;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [PAGE_WIDTH-1:0] page_t;
	typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// The address of a line request is always line aligned.
	typedef struct packed {
		logic write;
		addr_t addr;
		line_t wdata;
	} line_req_t;

	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	function automatic page_t page_of(addr_t addr);
		return addr[ADDR_WIDTH-1:OFFSET_BITS];
	endfunction

	function automatic word_sel_t word_sel_of(addr_t addr);
		return addr[OFFSET_BITS-1:OFFSET_BITS-WORD_SEL_WIDTH];
	endfunction

	function automatic addr_t line_base(page_t page);
		return {page, {OFFSET_BITS{1'b0}}};
	endfunction

	// Word 0 sits in the low bits of a line.
	function automatic word_t word_of(line_t data, word_sel_t sel);
		return data[WORD_WIDTH*sel +: WORD_WIDTH];
	endfunction

	function automatic line_t with_word(line_t data, word_sel_t sel, word_t word_in);
		line_t result;
		result = data;
		result[WORD_WIDTH*sel +: WORD_WIDTH] = word_in;
		return result;
	endfunction

endpackage

`default_nettype wire

//--- design/line_cache.sv
`default_nettype none

module line_cache
	import cache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire i_request,
	input wire cpu_req_t i_cpu_req,
	output word_t o_rdata,
	output logic o_ready,

	output logic o_line_request,
	output line_req_t o_line_req,
	input wire i_line_done,
	input wire line_t i_line_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		DECIDE,
		WRITE_BACK,
		FETCH,
		FILL,
		ACCESS,
		WAIT_END
	} state_t;

	state_t state;

	page_t page;
	line_t line;
	logic valid;
	logic dirty;
	logic ready;

	page_t req_page;
	word_sel_t req_sel;
	logic hit;

	// The CPU holds its request stable, so the fields are used straight from the port.
	assign req_page = page_of(i_cpu_req.addr);
	assign req_sel = word_sel_of(i_cpu_req.addr);
	assign hit = valid && (req_page == page);

	// Ready falls together with the request, not a cycle later.
	assign o_ready = ready && i_request;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			valid <= 1'b0;
			dirty <= 1'b0;
			ready <= 1'b0;
			o_line_request <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_request) begin
						state <= DECIDE;
					end
				end

				DECIDE: begin
					if (hit) begin
						state <= ACCESS;
					end else if (valid && dirty) begin
						o_line_request <= 1'b1;
						state <= WRITE_BACK;
					end else begin
						state <= FETCH;
					end
				end

				WRITE_BACK: begin
					if (i_line_done) begin
						o_line_request <= 1'b0;
						dirty <= 1'b0;
						state <= FETCH;
					end
				end

				FETCH: begin
					o_line_request <= 1'b1;
					state <= FILL;
				end

				FILL: begin
					if (i_line_done) begin
						o_line_request <= 1'b0;
						valid <= 1'b1;
						state <= ACCESS;
					end
				end

				ACCESS: begin
					if (i_cpu_req.write) begin
						dirty <= 1'b1;
					end
					ready <= 1'b1;
					state <= WAIT_END;
				end

				WAIT_END: begin
					if (!i_request) begin
						ready <= 1'b0;
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Line contents, tag and burst payload.
	always_ff @(posedge i_clock) begin
		case (state)
			DECIDE: begin
				o_line_req.write <= 1'b1;
				o_line_req.addr <= line_base(page);
				o_line_req.wdata <= line;
			end

			FETCH: begin
				o_line_req.write <= 1'b0;
				o_line_req.addr <= line_base(req_page);
				o_line_req.wdata <= line;
			end

			FILL: begin
				if (i_line_done) begin
					page <= req_page;
					line <= i_line_rdata;
				end
			end

			ACCESS: begin
				if (i_cpu_req.write) begin
					line <= with_word(line, req_sel, i_cpu_req.wdata);
				end else begin
					o_rdata <= word_of(line, req_sel);
				end
			end

			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/line_burst.sv
`default_nettype none

module line_burst
	import cache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire i_line_request,
	input wire line_req_t i_line_req,
	output logic o_line_done,
	output line_t o_line_rdata,

	output logic o_mem_request,
	output mem_req_t o_mem_req,
	input wire i_mem_ready,
	input wire word_t i_mem_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		BEAT,
		DONE
	} state_t;

	localparam word_sel_t LAST_BEAT = word_sel_t'(BEATS_PER_LINE - 1);

	state_t state;
	word_sel_t beat;
	word_sel_t next_beat;
	logic start;
	logic beat_done;

	assign next_beat = beat + word_sel_t'(1);

	// In DONE the request is still high from the cache, and it is ignored there.
	assign start = (state == IDLE) && i_line_request;
	assign beat_done = (state == BEAT) && i_mem_ready;

	assign o_mem_request = (state == BEAT);
	assign o_line_done = (state == DONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			beat <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_line_request) begin
						beat <= '0;
						state <= BEAT;
					end
				end

				BEAT: begin
					if (i_mem_ready) begin
						if (beat == LAST_BEAT) begin
							state <= DONE;
						end else begin
							beat <= next_beat;
						end
					end
				end

				DONE: begin
					state <= IDLE;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Beat 0 is set up on start. Each completed beat moves to the next word.
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_mem_req.write <= i_line_req.write;
			o_mem_req.addr <= line_base(page_of(i_line_req.addr));
			o_mem_req.wdata <= word_of(i_line_req.wdata, '0);
		end else if (beat_done) begin
			o_mem_req.addr <= o_mem_req.addr + addr_t'(WORD_BYTES);
			o_mem_req.wdata <= word_of(i_line_req.wdata, next_beat);
		end
	end

	// Read words enter at the top, so after four beats word 0 is in the low bits.
	always_ff @(posedge i_clock) begin
		if (beat_done && !o_mem_req.write) begin
			o_line_rdata <= {i_mem_rdata, o_line_rdata[LINE_WIDTH-1:WORD_WIDTH]};
		end
	end

endmodule

`default_nettype wire

//--- design/cache_subsystem.sv
`default_nettype none

module cache_subsystem
	import cache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire i_request,
	input wire cpu_req_t i_cpu_req,
	output word_t o_rdata,
	output logic o_ready,

	output logic o_mem_request,
	output mem_req_t o_mem_req,
	input wire i_mem_ready,
	input wire word_t i_mem_rdata
);

	logic line_request;
	line_req_t line_req;
	logic line_done;
	line_t line_rdata;

	line_cache cache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),

		.i_request(i_request),
		.i_cpu_req(i_cpu_req),
		.o_rdata(o_rdata),
		.o_ready(o_ready),

		.o_line_request(line_request),
		.o_line_req(line_req),
		.i_line_done(line_done),
		.i_line_rdata(line_rdata)
	);

	// Whole lines go to memory as word beats.
	line_burst burst_i (
		.i_clock(i_clock),
		.i_reset(i_reset),

		.i_line_request(line_request),
		.i_line_req(line_req),
		.o_line_done(line_done),
		.o_line_rdata(line_rdata),

		.o_mem_request(o_mem_request),
		.o_mem_req(o_mem_req),
		.i_mem_ready(i_mem_ready),
		.i_mem_rdata(i_mem_rdata)
	);

endmodule

`default_nettype wire

//--- tb/sdram_model.sv
`default_nettype none

module sdram_model
	import cache_pkg::*;
#(
	parameter word_t FILL_PATTERN = 32'h5A3C_96E1,
	parameter int MAX_DELAY = 3
)
(
	input wire i_clock,
	input wire i_reset,
	input wire i_mem_request,
	input wire mem_req_t i_mem_req,
	output logic o_mem_ready,
	output word_t o_mem_rdata
);

	// Storage is sparse. A word that was never written reads as its preload value.
	word_t mem [logic [29:0]];
	int unsigned wait_count;

	function automatic word_t read_word(logic [29:0] word_addr);
		if (mem.exists(word_addr)) begin
			return mem[word_addr];
		end
		return {2'b00, word_addr} ^ FILL_PATTERN;
	endfunction

	initial begin
		o_mem_ready = 1'b0;
		o_mem_rdata = '0;
	end

	// Ready is a single-cycle pulse, so a new beat is never accepted in the pulse cycle.
	always @(posedge i_clock) begin
		o_mem_ready <= 1'b0;
		if (i_reset) begin
			wait_count <= 0;
		end else if (i_mem_request && !o_mem_ready) begin
			if (wait_count == 0) begin
				o_mem_ready <= 1'b1;
				if (i_mem_req.write) begin
					mem[i_mem_req.addr[31:2]] = i_mem_req.wdata;
				end else begin
					o_mem_rdata <= read_word(i_mem_req.addr[31:2]);
				end
				wait_count <= $urandom % (MAX_DELAY + 1);
			end else begin
				wait_count <= wait_count - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/cache_subsystem_assertions.sv
`default_nettype none

module cache_subsystem_assertions
	import cache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire cpu_req_t i_cpu_req,
	input wire o_ready,
	input wire o_mem_request,
	input wire mem_req_t o_mem_req,
	input wire i_mem_ready
);

	int failure_count = 0;

	// Memory traffic only happens while a CPU miss is waiting.
	mem_needs_cpu_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_mem_request |-> i_request)
	else begin
		$error("memory request is high while no CPU request is pending");
		failure_count = failure_count + 1;
	end

	// The CPU keeps its request up and unchanged until the cache answers.
	cpu_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && !o_ready |=> i_request && $stable(i_cpu_req))
	else begin
		$error("CPU request dropped or changed before o_ready");
		failure_count = failure_count + 1;
	end

	mem_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_mem_request && !i_mem_ready |=> o_mem_request && $stable(o_mem_req))
	else begin
		$error("memory request dropped or changed before i_mem_ready");
		failure_count = failure_count + 1;
	end

	beat_address_steps: assert property (@(posedge i_clock) disable iff (i_reset)
		o_mem_request && i_mem_ready |=>
			!o_mem_request || o_mem_req.addr == $past(o_mem_req.addr) + addr_t'(WORD_BYTES))
	else begin
		$error("beat address did not advance by one word");
		failure_count = failure_count + 1;
	end

endmodule

`default_nettype wire

//--- tb/cache_subsystem_tb.sv
`default_nettype none

module cache_subsystem_tb
	import cache_pkg::*;
();

	localparam int SEED = 43;
	localparam int RESET_CYCLES = 10;
	localparam word_t FILL_PATTERN = 32'h5A3C_96E1;
	localparam int MAX_DELAY = 3;
	localparam int HIT_LATENCY = 2;
	localparam int RANDOM_ACCESSES = 200;
	localparam int RANDOM_LINES = 3;
	localparam addr_t RANDOM_BASE = 32'h0000_4000;
	// Worst miss writes a line back and fetches one, every beat at the longest delay.
	localparam int WORST_ACCESS_CYCLES = 2 * BEATS_PER_LINE * (MAX_DELAY + 2) + 10;
	localparam int ACCESS_COUNT = RANDOM_ACCESSES + 16;
	localparam int TIMEOUT_CYCLES = ACCESS_COUNT * WORST_ACCESS_CYCLES + 4 * RESET_CYCLES;

	logic clock;
	logic reset;
	logic request;
	cpu_req_t cpu_req;
	word_t rdata;
	logic ready;
	logic mem_request;
	mem_req_t mem_req;
	logic mem_ready;
	word_t mem_rdata;

	word_t shadow [logic [29:0]];
	mem_req_t beats [$];
	int cycle_count = 0;

	cache_subsystem dut_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_cpu_req(cpu_req),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_mem_request(mem_request),
		.o_mem_req(mem_req),
		.i_mem_ready(mem_ready),
		.i_mem_rdata(mem_rdata)
	);

	sdram_model #(
		.FILL_PATTERN(FILL_PATTERN),
		.MAX_DELAY(MAX_DELAY)
	) memory_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_mem_request(mem_request),
		.i_mem_req(mem_req),
		.o_mem_ready(mem_ready),
		.o_mem_rdata(mem_rdata)
	);

	bind cache_subsystem cache_subsystem_assertions assertions_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_cpu_req(i_cpu_req),
		.o_ready(o_ready),
		.o_mem_request(o_mem_request),
		.o_mem_req(o_mem_req),
		.i_mem_ready(i_mem_ready)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first failure.");
	endtask

	// Every completed memory beat is recorded for the burst checks.
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (mem_request && mem_ready) begin
			beats.push_back(mem_req);
		end
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles.", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_mem_req(input string name, input mem_req_t expected,
			input mem_req_t actual);
		if (expected !== actual) begin
			$display("ERR %s: expected write=%0b addr=%h wdata=%h, actual write=%0b addr=%h wdata=%h",
				name, expected.write, expected.addr, expected.wdata,
				actual.write, actual.addr, actual.wdata);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	function automatic word_t expected_word(addr_t addr);
		if (shadow.exists(addr[31:2])) begin
			return shadow[addr[31:2]];
		end
		return {2'b00, addr[31:2]} ^ FILL_PATTERN;
	endfunction

	task automatic apply_reset();
		reset <= 1'b1;
		request <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		beats.delete();
	endtask

	// Ready is seen one edge after it rises, so the delay is counted back by one.
	task automatic cpu_access(input logic write, input addr_t addr, input word_t wdata,
			output word_t value, output int ready_delay);
		int edges;
		@(posedge clock);
		request <= 1'b1;
		cpu_req <= {write, addr, wdata};
		@(posedge clock);
		edges = 0;
		do begin
			@(posedge clock);
			edges++;
		end while (!ready);
		value = rdata;
		ready_delay = edges - 1;
		request <= 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input word_t data);
		word_t value;
		int ready_delay;
		cpu_access(1'b1, addr, data, value, ready_delay);
		shadow[addr[31:2]] = data;
	endtask

	task automatic read_check(input string name, input addr_t addr, output int ready_delay);
		word_t value;
		cpu_access(1'b0, addr, '0, value, ready_delay);
		check_word(name, expected_word(addr), value);
	endtask

	task automatic check_beats(input string name, input int first, input logic write,
			input addr_t base);
		mem_req_t expected;
		mem_req_t actual;
		for (int i = 0; i < BEATS_PER_LINE; i++) begin
			actual = beats[first + i];
			// Write data carries no meaning on a read beat.
			if (!write) begin
				actual.wdata = '0;
			end
			expected.write = write;
			expected.addr = base + addr_t'(WORD_BYTES * i);
			expected.wdata = write ? expected_word(expected.addr) : '0;
			check_mem_req(name, expected, actual);
		end
	endtask

	task automatic test_read_miss();
		int ready_delay;
		beats.delete();
		read_check("read_miss", 32'h0000_1008, ready_delay);
		check_count("read_miss beats", BEATS_PER_LINE, beats.size());
		check_beats("read_miss", 0, 1'b0, 32'h0000_1000);
	endtask

	task automatic test_write_hit();
		int ready_delay;
		beats.delete();
		write_word(32'h0000_1008, 32'hCAFE_0001);
		read_check("write_hit", 32'h0000_1008, ready_delay);
		check_count("write_hit latency", HIT_LATENCY, ready_delay);
		check_count("write_hit beats", 0, beats.size());
	endtask

	task automatic test_write_back();
		int ready_delay;
		write_word(32'h0000_1004, 32'hBEEF_0002);
		beats.delete();
		read_check("write_back", 32'h0000_2004, ready_delay);
		check_count("write_back beats", 2 * BEATS_PER_LINE, beats.size());
		check_beats("write_back", 0, 1'b1, 32'h0000_1000);
		check_beats("write_back fetch", BEATS_PER_LINE, 1'b0, 32'h0000_2000);
		read_check("write_back reread", 32'h0000_1008, ready_delay);
		read_check("write_back reread", 32'h0000_1004, ready_delay);
	endtask

	task automatic test_clean_miss();
		int ready_delay;
		beats.delete();
		read_check("clean_miss", 32'h0000_3010, ready_delay);
		check_count("clean_miss beats", BEATS_PER_LINE, beats.size());
		check_beats("clean_miss", 0, 1'b0, 32'h0000_3010);
	endtask

	task automatic test_reset_mid_run();
		int ready_delay;
		beats.delete();
		read_check("reset_mid_run hit", 32'h0000_3014, ready_delay);
		check_count("reset_mid_run hit beats", 0, beats.size());
		apply_reset();
		read_check("reset_mid_run", 32'h0000_3014, ready_delay);
		check_count("reset_mid_run beats", BEATS_PER_LINE, beats.size());
		check_beats("reset_mid_run", 0, 1'b0, 32'h0000_3010);
	endtask

	task automatic test_random_traffic();
		addr_t addr;
		word_t data;
		logic write;
		int ready_delay;
		for (int n = 0; n < RANDOM_ACCESSES; n++) begin
			addr = RANDOM_BASE + addr_t'(($urandom % RANDOM_LINES) * 16)
				+ addr_t'(($urandom % BEATS_PER_LINE) * WORD_BYTES);
			write = ($urandom % 2) != 0;
			data = $urandom;
			if (write) begin
				write_word(addr, data);
			end else begin
				read_check("random", addr, ready_delay);
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		request = 1'b0;
		cpu_req = '0;
		apply_reset();
		test_read_miss();
		test_write_hit();
		test_write_back();
		test_clean_miss();
		test_reset_mid_run();
		test_random_traffic();
		repeat (4) @(posedge clock);
		if (dut_i.assertions_i.failure_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times.", dut_i.assertions_i.failure_count);
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- cache_subsystem.f
design/cache_pkg.sv
design/line_cache.sv
design/line_burst.sv
design/cache_subsystem.sv
tb/sdram_model.sv
tb/cache_subsystem_assertions.sv
tb/cache_subsystem_tb.sv

//--- Makefile
TOP = cache_subsystem_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

obj_dir/V$(TOP): cache_subsystem.f design/*.sv tb/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f cache_subsystem.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f cache_subsystem.f

clean:
	rm -rf obj_dir sim.log
